/* src.f */
hdl/vai_pkg.sv
hdl/tenant_offset_regs.sv
hdl/tenant_tx_audit.sv
hdl/req_fifo.sv
hdl/tx_round_robin.sv
hdl/vai_tx_top.sv
testbench/vai_tx_props.sv
testbench/vai_tx_tb.sv

/* Makefile */
# Verilator build and run for the tenant request path

VERILATOR   ?= verilator
TOP         ?= vai_tx_tb
FILELIST    ?= src.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --timing --assert
BUILD_FLAGS ?= --binary -j 0
PASS_MSG    ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) $(BUILD_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/vai_tx_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module vai_tx_tb;

    localparam int NT         = 4;
    localparam int FIFO_DEPTH = 8;
    localparam int TAG_W      = $clog2(NT);
    localparam int LOW_W      = vai_pkg::MDATA_W - TAG_W;

    logic              clk;
    logic              reset;
    vai_pkg::c0_req_t  tenant_c0 [NT-1:0];
    vai_pkg::c1_req_t  tenant_c1 [NT-1:0];
    logic [NT-1:0]     tenant_c0_almost_full;
    logic [NT-1:0]     tenant_c1_almost_full;
    vai_pkg::c0_req_t  up_c0;
    vai_pkg::c1_req_t  up_c1;
    logic              up_c0_ready;
    logic              up_c1_ready;
    logic              cfg_req;
    logic [TAG_W-1:0]  cfg_tenant;
    vai_pkg::cl_addr_t cfg_offset;
    logic              cfg_ack;

    integer            seed = 32'h49d;
    string             phase = "reset";
    vai_pkg::cl_addr_t cur_off [NT] = '{default: '0};   // Offsets the DUT should hold
    vai_pkg::c0_req_t  exp_c0 [NT][$];
    vai_pkg::c1_req_t  exp_c1 [NT][$];
    bit                fair_check = 1'b0;
    int                last_c0 = -1;
    int                last_c1 = -1;
    int                grants_c0 [NT] = '{default: 0};
    int                grants_c1 [NT] = '{default: 0};

    vai_tx_top #(.NUM_TENANTS(NT), .FIFO_DEPTH(FIFO_DEPTH)) uut (
        .clk(clk), .reset(reset),
        .tenant_c0(tenant_c0), .tenant_c1(tenant_c1),
        .tenant_c0_almost_full(tenant_c0_almost_full),
        .tenant_c1_almost_full(tenant_c1_almost_full),
        .up_c0(up_c0), .up_c0_ready(up_c0_ready),
        .up_c1(up_c1), .up_c1_ready(up_c1_ready),
        .cfg_req(cfg_req), .cfg_tenant(cfg_tenant), .cfg_offset(cfg_offset),
        .cfg_ack(cfg_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_c0(input string name, input vai_pkg::c0_req_t want,
                            input vai_pkg::c0_req_t got);
        if (got !== want)
            stop_with_error($sformatf("FAIL %s: expected %h, actual %h", name, want, got));
    endtask

    task automatic check_c1(input string name, input vai_pkg::c1_req_t want,
                            input vai_pkg::c1_req_t got);
        if (got !== want)
            stop_with_error($sformatf("FAIL %s: expected %h, actual %h", name, want, got));
    endtask

    task automatic expect_flags(input string name, input logic [NT-1:0] want,
                                input logic [NT-1:0] got);
        if (got !== want)
            stop_with_error($sformatf("FAIL %s: expected %b, actual %b", name, want, got));
    endtask

    // Relocate by the tenant offset and put the tenant index in the top mdata bits
    function automatic vai_pkg::c0_hdr_t ref_c0_hdr(input int t, input vai_pkg::c0_hdr_t h,
                                                    input vai_pkg::cl_addr_t off);
        vai_pkg::c0_hdr_t e;
        e = h;
        e.address = h.address + off;
        e.mdata = {TAG_W'(t), h.mdata[LOW_W-1:0]};
        return e;
    endfunction

    function automatic vai_pkg::c1_hdr_t ref_c1_hdr(input int t, input vai_pkg::c1_hdr_t h,
                                                    input vai_pkg::cl_addr_t off);
        vai_pkg::c1_hdr_t e;
        e = h;
        e.address = (h.req_type == vai_pkg::REQ_WRFENCE) ? '0 : h.address + off;
        e.mdata = {TAG_W'(t), h.mdata[LOW_W-1:0]};
        return e;
    endfunction

    function automatic bit chance(input int pct);
        return int'($unsigned($random(seed)) % 32'd100) < pct;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int t = 0; t < NT; t++)
            n += exp_c0[t].size() + exp_c1[t].size();
        return n;
    endfunction

    // Present one cycle of traffic for tenant t and record what should come out
    task automatic issue(input int t, input bit send_c0, input bit send_c1, input bit fence);
        vai_pkg::c0_req_t r0;
        vai_pkg::c1_req_t r1;
        vai_pkg::c0_req_t e0;
        vai_pkg::c1_req_t e1;
        r0 = '0;
        r1 = '0;
        if (send_c0)
        begin
            r0.valid        = 1'b1;
            r0.hdr.address  = vai_pkg::cl_addr_t'($random(seed));
            r0.hdr.req_type = vai_pkg::REQ_READ;
            r0.hdr.cl_len   = 2'($random(seed));
            r0.hdr.mdata    = vai_pkg::mdata_t'($random(seed));
            e0 = r0;
            e0.hdr = ref_c0_hdr(t, r0.hdr, cur_off[t]);
            exp_c0[t].push_back(e0);
        end
        if (send_c1)
        begin
            r1.valid        = 1'b1;
            r1.hdr.address  = vai_pkg::cl_addr_t'($random(seed));
            r1.hdr.req_type = fence ? vai_pkg::REQ_WRFENCE : vai_pkg::REQ_WRITE;
            r1.hdr.cl_len   = 2'($random(seed));
            r1.hdr.sop      = 1'($random(seed));
            r1.hdr.mdata    = vai_pkg::mdata_t'($random(seed));
            r1.data         = {$random(seed), $random(seed)};
            e1 = r1;
            e1.hdr = ref_c1_hdr(t, r1.hdr, cur_off[t]);
            exp_c1[t].push_back(e1);
        end
        tenant_c0[t] = r0;
        tenant_c1[t] = r1;
    endtask

    task automatic traffic(input int cycles, input int rate, input int ready_pct);
        for (int c = 0; c < cycles; c++)
        begin
            @(posedge clk);
            #1;
            up_c0_ready = chance(ready_pct);
            up_c1_ready = chance(ready_pct);
            for (int t = 0; t < NT; t++)
                issue(t, !tenant_c0_almost_full[t] && chance(rate),
                      !tenant_c1_almost_full[t] && chance(rate), chance(25));
        end
        @(posedge clk);
        #1;
        for (int t = 0; t < NT; t++)
            issue(t, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic drain();
        int n;
        @(posedge clk);
        #1;
        up_c0_ready = 1'b1;
        up_c1_ready = 1'b1;
        n = 0;
        while (pending() != 0)
        begin
            @(posedge clk);
            n++;
            if (n > 500)
                stop_with_error($sformatf("Timeout in %s: %0d requests never arrived",
                                          phase, pending()));
        end
    endtask

    // Four-phase write of one tenant offset
    task automatic write_offset(input int t, input vai_pkg::cl_addr_t off);
        int n;
        @(posedge clk);
        #1;
        cfg_req    = 1'b1;
        cfg_tenant = TAG_W'(t);
        cfg_offset = off;
        n = 0;
        while (!cfg_ack)
        begin
            @(posedge clk);
            #1;
            n++;
            if (n > 20)
                stop_with_error("Timeout: cfg_ack never rose");
        end
        cur_off[t] = off;
        @(posedge clk);   // Host keeps req up one more cycle
        #1;
        if (!cfg_ack)
            stop_with_error("cfg_ack dropped while cfg_req was still high");
        cfg_req = 1'b0;
        n = 0;
        while (cfg_ack)
        begin
            @(posedge clk);
            #1;
            n++;
            if (n > 20)
                stop_with_error("Timeout: cfg_ack never fell after cfg_req dropped");
        end
    endtask

    // Scoreboard, sampled mid-cycle where valid and ready are settled
    always @(negedge clk)
    begin : compare
        int t;
        if (!reset && up_c0.valid && up_c0_ready)
        begin
            t = int'(up_c0.hdr.mdata[vai_pkg::MDATA_W-1 -: TAG_W]);
            if (exp_c0[t].size() == 0)
                stop_with_error($sformatf("Unexpected read request for tenant %0d", t));
            check_c0({phase, " c0"}, exp_c0[t].pop_front(), up_c0);
            if (fair_check && t == last_c0)
                stop_with_error($sformatf("Tenant %0d got two c0 grants in a row", t));
            if (fair_check)
                grants_c0[t]++;
            last_c0 = t;
        end
        if (!reset && up_c1.valid && up_c1_ready)
        begin
            t = int'(up_c1.hdr.mdata[vai_pkg::MDATA_W-1 -: TAG_W]);
            if (exp_c1[t].size() == 0)
                stop_with_error($sformatf("Unexpected write request for tenant %0d", t));
            check_c1({phase, " c1"}, exp_c1[t].pop_front(), up_c1);
            if (fair_check && t == last_c1)
                stop_with_error($sformatf("Tenant %0d got two c1 grants in a row", t));
            if (fair_check)
                grants_c1[t]++;
            last_c1 = t;
        end
    end

    initial
    begin
        reset       = 1'b1;
        cfg_req     = 1'b0;
        cfg_tenant  = '0;
        cfg_offset  = '0;
        up_c0_ready = 1'b0;
        up_c1_ready = 1'b0;
        for (int t = 0; t < NT; t++)
        begin
            tenant_c0[t] = '0;
            tenant_c1[t] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        expect_flags("reset c0 almost_full", '0, tenant_c0_almost_full);
        expect_flags("reset c1 almost_full", '0, tenant_c1_almost_full);

        phase = "config";
        for (int t = 0; t < NT; t++)
            write_offset(t, vai_pkg::cl_addr_t'(32'h0100_0000 * (t + 1) + 32'h40 * t));

        phase = "directed";   // Read and write, then a fence, from every tenant
        @(posedge clk);
        #1;
        up_c0_ready = 1'b1;
        up_c1_ready = 1'b1;
        for (int t = 0; t < NT; t++)
            issue(t, 1'b1, 1'b1, 1'b0);
        @(posedge clk);
        #1;
        for (int t = 0; t < NT; t++)
            issue(t, 1'b0, 1'b1, 1'b1);
        @(posedge clk);
        #1;
        for (int t = 0; t < NT; t++)
            issue(t, 1'b0, 1'b0, 1'b0);
        drain();

        phase = "random";
        traffic(300, 50, 50);
        drain();

        phase = "reconfig";
        write_offset(2, 32'h7777_0000);
        write_offset(0, 32'hffff_f000);   // Wraps around the address space
        traffic(150, 60, 50);
        drain();

        phase = "backpressure";   // Upstream stalled until every FIFO fills
        traffic(12, 100, 0);
        expect_flags("backpressure c0 almost_full", '1, tenant_c0_almost_full);
        expect_flags("backpressure c1 almost_full", '1, tenant_c1_almost_full);
        drain();

        phase = "saturate";
        traffic(12, 100, 100);
        fair_check = 1'b1;
        traffic(80, 100, 100);
        fair_check = 1'b0;
        drain();
        for (int t = 0; t < NT; t++)
            if (grants_c0[t] == 0 || grants_c1[t] == 0)
                stop_with_error($sformatf("Tenant %0d was starved under saturation", t));

        repeat (10) @(posedge clk);
        #1;
        expect_flags("idle c0 almost_full", '0, tenant_c0_almost_full);
        expect_flags("idle c1 almost_full", '0, tenant_c1_almost_full);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/vai_tx_props.sv */
`timescale 1ns/10ps
`default_nettype none

module vai_tx_props #(
    parameter int W = 1
)
(
    input wire             clk,
    input wire             reset,
    input wire [W-1:0]     out_bits,
    input wire             out_valid,
    input wire             out_ready,
    input wire             cfg_req,
    input wire             cfg_ack
);

    // Upstream stall freezes the whole output register
    hold_under_stall: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> $stable(out_bits))
        else $error("Output changed while the upstream side was stalling");

    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(cfg_ack) |-> $past(cfg_req))
        else $error("cfg_ack rose without a pending cfg_req");

    quiet_in_reset: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("Valid output seen during reset");

endmodule

bind tx_round_robin vai_tx_props #(.W($bits(out_req))) arb_props (
    .clk(clk), .reset(reset), .out_bits(out_req), .out_valid(out_req.valid),
    .out_ready(out_ready), .cfg_req(1'b0), .cfg_ack(1'b0)
);

// Ack must hold while the host keeps req high
bind tenant_offset_regs vai_tx_props #(.W(1)) cfg_props (
    .clk(clk), .reset(reset), .out_bits(cfg_ack), .out_valid(cfg_ack),
    .out_ready(!cfg_req), .cfg_req(cfg_req), .cfg_ack(cfg_ack)
);

`default_nettype wire

/* hdl/vai_tx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module vai_tx_top #(
    parameter int NUM_TENANTS = 4,
    parameter int FIFO_DEPTH  = 8,
    localparam int IDX_W = (NUM_TENANTS > 1) ? $clog2(NUM_TENANTS) : 1
)
(
    input  wire                             clk,
    input  wire                             reset,
    input  wire vai_pkg::c0_req_t           tenant_c0 [NUM_TENANTS-1:0],
    input  wire vai_pkg::c1_req_t           tenant_c1 [NUM_TENANTS-1:0],
    output wire logic [NUM_TENANTS-1:0]     tenant_c0_almost_full,
    output wire logic [NUM_TENANTS-1:0]     tenant_c1_almost_full,
    output vai_pkg::c0_req_t                up_c0,
    input  wire logic                       up_c0_ready,
    output vai_pkg::c1_req_t                up_c1,
    input  wire logic                       up_c1_ready,
    input  wire logic                       cfg_req,
    input  wire logic [IDX_W-1:0]           cfg_tenant,
    input  wire vai_pkg::cl_addr_t          cfg_offset,
    output logic                            cfg_ack
);

    vai_pkg::cl_addr_t offsets  [NUM_TENANTS-1:0];
    vai_pkg::c0_req_t  aud_c0   [NUM_TENANTS-1:0];
    vai_pkg::c1_req_t  aud_c1   [NUM_TENANTS-1:0];
    vai_pkg::c0_req_t  c0_heads [NUM_TENANTS-1:0];
    vai_pkg::c1_req_t  c1_heads [NUM_TENANTS-1:0];
    wire [NUM_TENANTS-1:0] c0_empty;
    wire [NUM_TENANTS-1:0] c1_empty;
    wire [NUM_TENANTS-1:0] c0_pop;
    wire [NUM_TENANTS-1:0] c1_pop;

    tenant_offset_regs #(.NUM_TENANTS(NUM_TENANTS)) offset_regs (
        .clk(clk), .reset(reset),
        .cfg_req(cfg_req), .cfg_tenant(cfg_tenant), .cfg_offset(cfg_offset),
        .cfg_ack(cfg_ack), .offsets(offsets)
    );

    for (genvar n = 0; n < NUM_TENANTS; n++)
    begin : g_tenant
        tenant_tx_audit #(.NUM_TENANTS(NUM_TENANTS), .TENANT_ID(n)) audit (
            .clk(clk), .reset(reset),
            .in_c0(tenant_c0[n]), .in_c1(tenant_c1[n]), .offset(offsets[n]),
            .out_c0(aud_c0[n]), .out_c1(aud_c1[n])
        );

        req_fifo #(.req_t(vai_pkg::c0_req_t), .FIFO_DEPTH(FIFO_DEPTH)) c0_fifo (
            .clk(clk), .reset(reset),
            .push(aud_c0[n].valid), .push_data(aud_c0[n]), .pop(c0_pop[n]),
            .head(c0_heads[n]), .empty(c0_empty[n]),
            .almost_full(tenant_c0_almost_full[n])
        );

        req_fifo #(.req_t(vai_pkg::c1_req_t), .FIFO_DEPTH(FIFO_DEPTH)) c1_fifo (
            .clk(clk), .reset(reset),
            .push(aud_c1[n].valid), .push_data(aud_c1[n]), .pop(c1_pop[n]),
            .head(c1_heads[n]), .empty(c1_empty[n]),
            .almost_full(tenant_c1_almost_full[n])
        );
    end

    // One merge per channel
    tx_round_robin #(.req_t(vai_pkg::c0_req_t), .NUM_TENANTS(NUM_TENANTS)) c0_arb (
        .clk(clk), .reset(reset),
        .heads(c0_heads), .empty(c0_empty), .pop(c0_pop),
        .out_req(up_c0), .out_ready(up_c0_ready)
    );

    tx_round_robin #(.req_t(vai_pkg::c1_req_t), .NUM_TENANTS(NUM_TENANTS)) c1_arb (
        .clk(clk), .reset(reset),
        .heads(c1_heads), .empty(c1_empty), .pop(c1_pop),
        .out_req(up_c1), .out_ready(up_c1_ready)
    );

endmodule

`default_nettype wire

/* hdl/tx_round_robin.sv */
`timescale 1ns/10ps
`default_nettype none

module tx_round_robin #(
    parameter type req_t       = vai_pkg::c0_req_t,
    parameter int  NUM_TENANTS = 4
)
(
    input  wire                             clk,
    input  wire                             reset,
    input  wire req_t                       heads [NUM_TENANTS-1:0],
    input  wire logic [NUM_TENANTS-1:0]     empty,
    output logic [NUM_TENANTS-1:0]          pop,
    output req_t                            out_req,
    input  wire logic                       out_ready
);

    localparam int IDX_W = (NUM_TENANTS > 1) ? $clog2(NUM_TENANTS) : 1;

    logic [IDX_W-1:0] last_grant;
    logic [IDX_W-1:0] grant_idx;
    logic             grant_any;
    logic             load;

    // Output register is free or being drained this cycle
    assign load = !out_req.valid || out_ready;

    // Search starts just after the last granted tenant
    always_comb
    begin
        int idx;
        grant_any = 1'b0;
        grant_idx = last_grant;
        for (int i = 1; i <= NUM_TENANTS; i++)
        begin
            idx = (int'(last_grant) + i) % NUM_TENANTS;
            if (!grant_any && !empty[idx])
            begin
                grant_any = 1'b1;
                grant_idx = IDX_W'(idx);
            end
        end
    end

    always_comb
    begin
        pop = '0;
        if (load && grant_any)
        begin
            pop[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            out_req       <= heads[grant_idx];
            out_req.valid <= grant_any;
        end
        if (reset)
        begin
            out_req.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            last_grant <= IDX_W'(NUM_TENANTS - 1);   // Tenant 0 first
        end
        else if (load && grant_any)
        begin
            last_grant <= grant_idx;
        end
    end

endmodule

`default_nettype wire

/* hdl/req_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module req_fifo #(
    parameter type req_t      = vai_pkg::c0_req_t,
    parameter int  FIFO_DEPTH = 8
)
(
    input  wire         clk,
    input  wire         reset,
    input  wire logic   push,
    input  wire req_t   push_data,
    input  wire logic   pop,
    output req_t        head,
    output logic        empty,
    output logic        almost_full
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    req_t             mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty       = (count == '0);
    assign almost_full = (count >= CNT_W'(FIFO_DEPTH - 3));   // Room for audit flight
    assign do_push     = push && (count != CNT_W'(FIFO_DEPTH));
    assign do_pop      = pop && !empty;
    assign head        = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop)
            begin
                count <= count + 1'b1;
            end
            else if (do_pop && !do_push)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/tenant_tx_audit.sv */
`timescale 1ns/10ps
`default_nettype none

module tenant_tx_audit #(
    parameter int NUM_TENANTS = 4,
    parameter int TENANT_ID   = 0
)
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire vai_pkg::c0_req_t   in_c0,
    input  wire vai_pkg::c1_req_t   in_c1,
    input  wire vai_pkg::cl_addr_t  offset,
    output vai_pkg::c0_req_t        out_c0,
    output vai_pkg::c1_req_t        out_c1
);

    localparam int TAG_W = (NUM_TENANTS > 1) ? $clog2(NUM_TENANTS) : 1;
    localparam int LOW_W = vai_pkg::MDATA_W - TAG_W;
    localparam logic [TAG_W-1:0] TAG = TAG_W'(TENANT_ID);

    vai_pkg::c0_req_t  s1_c0;
    vai_pkg::c1_req_t  s1_c1;
    vai_pkg::cl_addr_t s1_offset;

    vai_pkg::c0_req_t  c0_next;
    vai_pkg::c1_req_t  c1_next;

    // Stage 1 captures requests and the tenant's current offset
    always_ff @(posedge clk)
    begin
        s1_c0     <= in_c0;
        s1_c1     <= in_c1;
        s1_offset <= offset;
        if (reset)
        begin
            s1_c0.valid <= 1'b0;
            s1_c1.valid <= 1'b0;
        end
    end

    always_comb
    begin
        c0_next = s1_c0;
        c0_next.hdr.address = s1_c0.hdr.address + s1_offset;
        c0_next.hdr.mdata   = {TAG, s1_c0.hdr.mdata[LOW_W-1:0]};

        c1_next = s1_c1;
        if (s1_c1.hdr.req_type == vai_pkg::REQ_WRFENCE)
        begin
            c1_next.hdr.address = '0;   // Fences carry no address
        end
        else
        begin
            c1_next.hdr.address = s1_c1.hdr.address + s1_offset;
        end
        // Tenant's own low bits pass through untouched
        c1_next.hdr.mdata = {TAG, s1_c1.hdr.mdata[LOW_W-1:0]};
    end

    // Stage 2 output register
    always_ff @(posedge clk)
    begin
        out_c0 <= c0_next;
        out_c1 <= c1_next;
        if (reset)
        begin
            out_c0.valid <= 1'b0;
            out_c1.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/tenant_offset_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module tenant_offset_regs #(
    parameter int NUM_TENANTS = 4,
    localparam int IDX_W = (NUM_TENANTS > 1) ? $clog2(NUM_TENANTS) : 1
)
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire logic               cfg_req,
    input  wire logic [IDX_W-1:0]   cfg_tenant,
    input  wire vai_pkg::cl_addr_t  cfg_offset,
    output logic                    cfg_ack,
    output vai_pkg::cl_addr_t       offsets [NUM_TENANTS-1:0]
);

    logic cfg_write;

    // New request seen while ack is still low
    assign cfg_write = cfg_req && !cfg_ack;

    // Four-phase acknowledge
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cfg_ack <= 1'b0;
        end
        else if (cfg_write)
        begin
            cfg_ack <= 1'b1;
        end
        else if (!cfg_req)
        begin
            cfg_ack <= 1'b0;   // Host has released req
        end
    end

    // Offset table, one entry per tenant
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < NUM_TENANTS; i++)
            begin
                offsets[i] <= '0;
            end
        end
        else if (cfg_write && (int'(cfg_tenant) < NUM_TENANTS))
        begin
            offsets[cfg_tenant] <= cfg_offset;   // Same edge that raises ack
        end
    end

endmodule

`default_nettype wire

/* hdl/vai_pkg.sv */
`default_nettype none

package vai_pkg;

    localparam int MDATA_W   = 16;
    localparam int CL_ADDR_W = 32;
    localparam int CL_LEN_W  = 2;
    localparam int DATA_W    = 64;   // Reduced from a full cache line

    typedef logic [CL_ADDR_W-1:0] cl_addr_t;
    typedef logic [MDATA_W-1:0]   mdata_t;

    typedef enum logic [1:0] {
        REQ_READ    = 2'd0,
        REQ_WRITE   = 2'd1,
        REQ_WRFENCE = 2'd2
    } req_type_t;

    typedef struct packed {
        cl_addr_t              address;
        req_type_t             req_type;
        logic [CL_LEN_W-1:0]   cl_len;   // Carried through, not interpreted
        mdata_t                mdata;
    } c0_hdr_t;

    typedef struct packed {
        cl_addr_t              address;
        req_type_t             req_type;
        logic [CL_LEN_W-1:0]   cl_len;
        logic                  sop;
        mdata_t                mdata;
    } c1_hdr_t;

    // Valid sits in the top bit of both request structs
    typedef struct packed {
        logic    valid;
        c0_hdr_t hdr;
    } c0_req_t;

    typedef struct packed {
        logic                valid;
        c1_hdr_t             hdr;
        logic [DATA_W-1:0]   data;
    } c1_req_t;

endpackage

`default_nettype wire
